/* hdl/fcs_crc32.sv */
`timescale 1ns/10ps
`default_nettype none

module fcs_crc32 (
  input  wire         gmii_tx_clk,
  input  wire         sys_rst,
  input  wire         crc_init,
  input  wire  [7:0]  data,
  input  wire         crc_data_en,
  output logic [31:0] crc_out
);

  // reflected form of 0x04C11DB7
  localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;

  logic [31:0] crc_reg;
  logic [31:0] crc_next;
  logic [31:0] crc_cur;

  // one byte, LSB first as it leaves on the wire
  function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] d);
    logic [31:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      if (c[0] ^ d[i]) begin
        c = (c >> 1) ^ CRC_POLY;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

  assign crc_next = crc_byte(crc_reg, data);

  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst || crc_init) begin
      crc_reg <= '1;
    end else if (crc_data_en) begin
      crc_reg <= crc_next;
    end
  end

  // includes the byte being fed this cycle, so the
  // last payload byte and the first FCS byte can share a cycle
  assign crc_cur = crc_data_en ? crc_next : crc_reg;

  // inverted; low byte of the register goes out first
  assign crc_out = ~{crc_cur[7:0], crc_cur[15:8], crc_cur[23:16], crc_cur[31:24]};

endmodule

`default_nettype wire

/* hdl/time_base.sv */
`timescale 1ns/10ps
`default_nettype none
`include "tx_defs.svh"

module time_base (
  input  wire                          gmii_tx_clk,
  input  wire                          sys_rst,
  input  wire [`TX_NUM_TIMERS-1:0]     local_time_req,
  output tx_pkg::time48_t              global_time,
  output tx_pkg::local_time_arr_t      local_times
);

  // free running, wraps at 2^48
  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      global_time <= '0;
    end else begin
      global_time <= global_time + 48'd1;
    end
  end

  // request bit i loads local time i+1
  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      local_times <= '0;
    end else begin
      for (int i = 0; i < `TX_NUM_TIMERS; i++) begin
        if (local_time_req[i]) begin
          local_times[i] <= global_time;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/timed_frame_sender.sv */
`timescale 1ns/10ps
`default_nettype none
`include "tx_defs.svh"

module timed_frame_sender (
  input  wire                          gmii_tx_clk,
  input  wire                          sys_rst,
  input  wire [15:0]                   rd_data,
  input  wire tx_pkg::tx_ptr_t         mem_wr_ptr,
  input  wire tx_pkg::time48_t         global_time,
  input  wire tx_pkg::local_time_arr_t local_times,
  input  wire [31:0]                   crc_out,
  output tx_pkg::tx_ptr_t              rd_addr,
  output tx_pkg::tx_ptr_t              mem_rd_ptr,
  output logic [`TX_NUM_TIMERS-1:0]    local_time_req,
  output logic [7:0]                   gmii_txd,
  output logic                         gmii_tx_en,
  output logic                         crc_init,
  output logic                         crc_data_en
);

  import tx_pkg::*;

  localparam int               IFG_W    = $clog2(`TX_IFG_CYCLES);
  localparam logic [IFG_W-1:0] IFG_LAST = IFG_W'(`TX_IFG_CYCLES - 1);
  localparam logic [15:0]      PRE_LEN  = 16'(`TX_PREAMBLE_LEN);
  localparam logic [15:0]      SFD_POS  = PRE_LEN - 16'd1;
  localparam logic [2:0]       HDR_LAST = 3'(`TX_HDR_WORDS - 1);

  tx_state_t        tx_state;
  logic [IFG_W-1:0] ifg_count;
  logic [2:0]       hdr_count;
  logic [15:0]      tx_count;
  tx_ptr_t          rd_ptr;

  // header fields
  logic [15:0]      tx_frame_len;
  logic             launch_cmd;
  logic [2:0]       launch_sel;
  time48_t          launch_ofs;

  logic [7:0]       word_lo;
  time48_t          launch_base;
  logic             launch_due;
  logic             gap_done;
  logic             payload_odd;
  logic             payload_end;

  // selector 0 means launch relative to zero
  always_comb begin
    if (launch_sel == 3'd0) begin
      launch_base = '0;
    end else begin
      launch_base = local_times[launch_sel - 3'd1];
    end
  end

  // command frames request a local time capture while waiting
  always_comb begin
    local_time_req = '0;
    if (tx_state == tx_waiting && launch_cmd && launch_sel != 3'd0) begin
      local_time_req[launch_sel - 3'd1] = 1'b1;
    end
  end

  // modulo 2^48 target
  assign launch_due  = (global_time == time48_t'(launch_ofs + launch_base));
  assign gap_done    = (ifg_count == IFG_LAST);
  assign payload_odd = tx_count[0] ^ PRE_LEN[0];
  assign payload_end = (tx_count == tx_frame_len + PRE_LEN);
  assign rd_addr     = rd_ptr;

  // clear while the SFD is on the wire, then feed each payload byte
  assign crc_init    = (tx_state == tx_sending) && (tx_count == PRE_LEN);
  assign crc_data_en = (tx_state == tx_sending) && (tx_count > PRE_LEN);

  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      tx_state       <= tx_idle;
      ifg_count      <= '0;
      hdr_count      <= '0;
      tx_count       <= '0;
      rd_ptr         <= '0;
      mem_rd_ptr     <= '0;
      gmii_tx_en     <= 1'b0;
    end else begin
      gmii_tx_en     <= 1'b0;

      if (!gap_done) begin
        ifg_count <= ifg_count + 1'b1;
      end

      case (tx_state)
        tx_idle: begin
          // rd_ptr equals mem_rd_ptr here, so word 0 is already being read
          if (mem_rd_ptr != mem_wr_ptr) begin
            tx_state  <= tx_hdr_load;
            rd_ptr    <= mem_rd_ptr + 1'b1;
            hdr_count <= '0;
            tx_count  <= '0;
          end
        end
        tx_hdr_load: begin
          hdr_count <= hdr_count + 3'd1;
          if (hdr_count == HDR_LAST) begin
            tx_state <= tx_waiting;
          end else begin
            rd_ptr <= rd_ptr + 1'b1;
          end
        end
        tx_waiting: begin
          // command frames skip the gap
          if (launch_cmd) begin
            tx_state <= tx_sending;
          end else if (gap_done && (launch_ofs == '0 || launch_due)) begin
            tx_state <= tx_sending;
          end
        end
        tx_sending: begin
          tx_count   <= tx_count + 16'd1;
          gmii_tx_en <= 1'b1;
          if (payload_end) begin
            tx_state <= tx_fcs_1;
          end else if (tx_count >= PRE_LEN && !payload_odd) begin
            // next word arrives in time for the following high byte
            rd_ptr <= rd_ptr + 1'b1;
          end
        end
        tx_fcs_1: begin
          tx_state   <= tx_fcs_2;
          gmii_tx_en <= 1'b1;
        end
        tx_fcs_2: begin
          tx_state   <= tx_fcs_3;
          gmii_tx_en <= 1'b1;
        end
        tx_fcs_3: begin
          tx_state   <= tx_idle;
          gmii_tx_en <= 1'b1;
          ifg_count  <= '0;
          // release the frame's slots to the host
          mem_rd_ptr <= rd_ptr;
        end
        default: begin
          tx_state <= tx_idle;
        end
      endcase
    end
  end

  always_ff @(posedge gmii_tx_clk) begin
    if (tx_state == tx_hdr_load) begin
      case (hdr_count)
        3'd0: tx_frame_len <= rd_data;
        3'd1: begin
          launch_cmd <= rd_data[15];
          launch_sel <= rd_data[14:12];
        end
        3'd2: launch_ofs[47:32] <= rd_data;
        3'd3: launch_ofs[31:16] <= rd_data;
        3'd4: launch_ofs[15:0]  <= rd_data;
        // tag words are not sent
        default: ;
      endcase
    end

    case (tx_state)
      tx_sending: begin
        if (tx_count < SFD_POS) begin
          gmii_txd <= 8'h55;
        end else if (tx_count == SFD_POS) begin
          gmii_txd <= 8'hd5;
        end else if (payload_end) begin
          gmii_txd <= crc_out[31:24];
        end else if (!payload_odd) begin
          gmii_txd <= rd_data[15:8];
          word_lo  <= rd_data[7:0];
        end else begin
          gmii_txd <= word_lo;
        end
      end
      tx_fcs_1: gmii_txd <= crc_out[23:16];
      tx_fcs_2: gmii_txd <= crc_out[15:8];
      tx_fcs_3: gmii_txd <= crc_out[7:0];
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/tx_defs.svh */
`ifndef TX_DEFS_SVH
`define TX_DEFS_SVH

// slot buffer word address width, 2^14 words of 16 bits
`define TX_PTR_W 14

// idle cycles required between the last FCS byte and the next preamble
`define TX_IFG_CYCLES 12

// seven 0x55 bytes plus the SFD
`define TX_PREAMBLE_LEN 8

// captured local time registers, selectors 1 to 7
`define TX_NUM_TIMERS 7

// length, four timestamp words, two tag words
`define TX_HDR_WORDS 7

`endif

/* hdl/tx_pkg.sv */
`default_nettype none
`include "tx_defs.svh"

package tx_pkg;

  // sender FSM states
  typedef enum logic [2:0] {
    tx_idle     = 3'b000,
    tx_hdr_load = 3'b001,
    tx_waiting  = 3'b010,
    tx_sending  = 3'b011,
    tx_fcs_1    = 3'b100,
    tx_fcs_2    = 3'b101,
    tx_fcs_3    = 3'b110
  } tx_state_t;

  // word address into the slot buffer
  typedef logic [`TX_PTR_W-1:0] tx_ptr_t;

  // time base and local time values
  typedef logic [47:0] time48_t;

  // entry 0 holds local time 1
  typedef time48_t [`TX_NUM_TIMERS-1:0] local_time_arr_t;

endpackage

`default_nettype wire

/* hdl/tx_slot_buffer.sv */
`timescale 1ns/10ps
`default_nettype none
`include "tx_defs.svh"

module tx_slot_buffer (
  input  wire                  gmii_tx_clk,
  input  wire                  sys_rst,
  input  wire                  host_wr_en,
  input  wire [15:0]           host_wr_data,
  input  wire                  host_commit,
  input  wire tx_pkg::tx_ptr_t rd_addr,
  input  wire tx_pkg::tx_ptr_t mem_rd_ptr,
  output logic [15:0]          rd_data,
  output tx_pkg::tx_ptr_t      mem_wr_ptr,
  output logic                 buffer_full
);

  import tx_pkg::*;

  logic [15:0] mem [0:(1 << `TX_PTR_W) - 1];
  tx_ptr_t     wr_ptr;
  tx_ptr_t     wr_ptr_next;
  logic        wr_ok;

  // one slot kept free so that full and empty differ
  assign buffer_full = (tx_ptr_t'(wr_ptr + 1'b1) == mem_rd_ptr);

  // writes while full are dropped
  assign wr_ok       = host_wr_en && !buffer_full;
  assign wr_ptr_next = wr_ok ? tx_ptr_t'(wr_ptr + 1'b1) : wr_ptr;

  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      wr_ptr     <= '0;
      mem_wr_ptr <= '0;
    end else begin
      wr_ptr <= wr_ptr_next;
      // a commit in the same cycle as the last write includes that word
      if (host_commit) begin
        mem_wr_ptr <= wr_ptr_next;
      end
    end
  end

  always_ff @(posedge gmii_tx_clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= host_wr_data;
    end
    // data for rd_addr shows up one cycle later
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

/* hdl/tx_timing_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "tx_defs.svh"

module tx_timing_top (
  input  wire              gmii_tx_clk,
  input  wire              sys_rst,
  input  wire              host_wr_en,
  input  wire [15:0]       host_wr_data,
  input  wire              host_commit,
  output logic             buffer_full,
  output logic [7:0]       gmii_txd,
  output logic             gmii_tx_en,
  output tx_pkg::time48_t  global_time
);

  import tx_pkg::*;

  tx_ptr_t                   rd_addr;
  logic [15:0]               rd_data;
  tx_ptr_t                   mem_wr_ptr;
  tx_ptr_t                   mem_rd_ptr;
  logic [`TX_NUM_TIMERS-1:0] local_time_req;
  local_time_arr_t           local_times;
  logic                      crc_init;
  logic                      crc_data_en;
  logic [31:0]               crc_out;

  tx_slot_buffer tx_slot_buffer_i (
    .gmii_tx_clk  (gmii_tx_clk),
    .sys_rst      (sys_rst),
    .host_wr_en   (host_wr_en),
    .host_wr_data (host_wr_data),
    .host_commit  (host_commit),
    .rd_addr      (rd_addr),
    .mem_rd_ptr   (mem_rd_ptr),
    .rd_data      (rd_data),
    .mem_wr_ptr   (mem_wr_ptr),
    .buffer_full  (buffer_full)
  );

  time_base time_base_i (
    .gmii_tx_clk    (gmii_tx_clk),
    .sys_rst        (sys_rst),
    .local_time_req (local_time_req),
    .global_time    (global_time),
    .local_times    (local_times)
  );

  // CRC taps the byte already driven onto the GMII bus
  fcs_crc32 fcs_crc32_i (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .crc_init    (crc_init),
    .data        (gmii_txd),
    .crc_data_en (crc_data_en),
    .crc_out     (crc_out)
  );

  timed_frame_sender timed_frame_sender_i (
    .gmii_tx_clk    (gmii_tx_clk),
    .sys_rst        (sys_rst),
    .rd_data        (rd_data),
    .mem_wr_ptr     (mem_wr_ptr),
    .global_time    (global_time),
    .local_times    (local_times),
    .crc_out        (crc_out),
    .rd_addr        (rd_addr),
    .mem_rd_ptr     (mem_rd_ptr),
    .local_time_req (local_time_req),
    .gmii_txd       (gmii_txd),
    .gmii_tx_en     (gmii_tx_en),
    .crc_init       (crc_init),
    .crc_data_en    (crc_data_en)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the tx timing testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_tx_timing -f sim.f -o tb_tx_timing
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/tb_tx_timing)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1

/* sim.f */
+incdir+hdl
hdl/tx_pkg.sv
hdl/tx_slot_buffer.sv
hdl/fcs_crc32.sv
hdl/time_base.sv
hdl/timed_frame_sender.sv
hdl/tx_timing_top.sv
verif/tb_tx_timing.sv

/* verif/tb_tx_timing.sv */
`timescale 1ns/10ps
`default_nettype none
`include "tx_defs.svh"

module tb_tx_timing;

  import tx_pkg::*;

  localparam int NUM_FRAMES = 40;
  localparam int MAX_LEN    = 64;
  localparam int FCS_LEN    = 4;
  localparam int KIND_IMM   = 0;
  localparam int KIND_ZERO  = 1;
  localparam int KIND_LOCAL = 2;
  localparam int KIND_CMD   = 3;
  // write, header load, longest wait, frame on the wire and gap
  localparam int FRAME_CYCLES = (`TX_HDR_WORDS + MAX_LEN / 2) + 10 + 124
                                + (`TX_PREAMBLE_LEN + MAX_LEN + FCS_LEN) + `TX_IFG_CYCLES + 10;
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_CYCLES + 500;

  logic        gmii_tx_clk;
  logic        sys_rst;
  logic        host_wr_en;
  logic [15:0] host_wr_data;
  logic        host_commit;
  logic        buffer_full;
  logic [7:0]  gmii_txd;
  logic        gmii_tx_en;
  time48_t     global_time;

  integer      seed;
  int          errors;
  int          sent_count;
  int          rx_count;
  int          f_len    [NUM_FRAMES];
  int          f_kind   [NUM_FRAMES];
  logic [2:0]  f_sel    [NUM_FRAMES];
  time48_t     f_ofs    [NUM_FRAMES];
  time48_t     f_target [NUM_FRAMES];
  logic [7:0]  f_pay    [NUM_FRAMES][MAX_LEN];
  time48_t     model_local [1:`TX_NUM_TIMERS];

  // monitor state
  logic [7:0]  burst [$];
  bit          in_burst;
  longint      cyc;
  longint      burst_start;
  longint      last_end;
  time48_t     burst_time;
  bit          time_valid;
  time48_t     exp_time;

  tx_timing_top tx_timing_top_i (
    .gmii_tx_clk  (gmii_tx_clk),
    .sys_rst      (sys_rst),
    .host_wr_en   (host_wr_en),
    .host_wr_data (host_wr_data),
    .host_commit  (host_commit),
    .buffer_full  (buffer_full),
    .gmii_txd     (gmii_txd),
    .gmii_tx_en   (gmii_tx_en),
    .global_time  (global_time)
  );

  initial begin
    gmii_tx_clk = 1'b0;
    forever #4 gmii_tx_clk = ~gmii_tx_clk;
  end

  task automatic compare_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
    if (exp !== act) begin
      errors++;
      $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, exp, act);
    end
  endtask

  // reflected Ethernet CRC-32 computed bit by bit
  function automatic logic [31:0] ether_crc(input logic [31:0] crc, input logic [7:0] b);
    logic [31:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      c = (c[0] ^ b[i]) ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
    end
    return c;
  endfunction

  task automatic write_frame(input int idx);
    logic [15:0] w [`TX_HDR_WORDS + MAX_LEN / 2];
    logic [63:0] ts;
    int          nw;
    nw = `TX_HDR_WORDS + f_len[idx] / 2;
    ts = {(f_kind[idx] == KIND_CMD), f_sel[idx], 12'($random(seed)), f_ofs[idx]};
    w[0] = 16'(f_len[idx]);
    w[1] = ts[63:48];
    w[2] = ts[47:32];
    w[3] = ts[31:16];
    w[4] = ts[15:0];
    // tag words are never transmitted
    w[5] = 16'($random(seed));
    w[6] = 16'($random(seed));
    for (int i = 0; i < f_len[idx] / 2; i++) begin
      w[`TX_HDR_WORDS + i] = {f_pay[idx][2 * i], f_pay[idx][2 * i + 1]};
    end
    sent_count++;
    for (int i = 0; i < nw; i++) begin
      @(posedge gmii_tx_clk);
      host_wr_en   <= 1'b1;
      host_wr_data <= w[i];
      host_commit  <= (i == nw - 1);
    end
    @(posedge gmii_tx_clk);
    host_wr_en  <= 1'b0;
    host_commit <= 1'b0;
  endtask

  task automatic check_frame;
    int          idx;
    int          len;
    logic [31:0] crc;
    logic [31:0] fcs;
    longint      gap;
    idx = rx_count;
    rx_count++;
    if (idx >= sent_count) begin
      errors++;
      $display("ERROR: a frame appeared on GMII with no committed frame left to match it");
      return;
    end
    len = f_len[idx];
    compare_value($sformatf("frame %0d burst length", idx),
                  `TX_PREAMBLE_LEN + len + FCS_LEN, burst.size());
    if (burst.size() != `TX_PREAMBLE_LEN + len + FCS_LEN) begin
      return;
    end
    for (int i = 0; i < `TX_PREAMBLE_LEN - 1; i++) begin
      compare_value($sformatf("frame %0d preamble %0d", idx, i), 8'h55, burst[i]);
    end
    compare_value($sformatf("frame %0d sfd", idx), 8'hd5, burst[`TX_PREAMBLE_LEN - 1]);
    crc = '1;
    for (int i = 0; i < len; i++) begin
      compare_value($sformatf("frame %0d payload %0d", idx, i), f_pay[idx][i],
                    burst[`TX_PREAMBLE_LEN + i]);
      crc = ether_crc(crc, f_pay[idx][i]);
    end
    fcs = ~crc;
    for (int i = 0; i < FCS_LEN; i++) begin
      compare_value($sformatf("frame %0d fcs %0d", idx, i), fcs[8 * i +: 8],
                    burst[`TX_PREAMBLE_LEN + len + i]);
    end
    if (f_kind[idx] == KIND_ZERO || f_kind[idx] == KIND_LOCAL) begin
      compare_value($sformatf("frame %0d launch time", idx),
                    time48_t'(f_target[idx] + 48'd2), burst_time);
    end
    if (f_kind[idx] == KIND_CMD) begin
      // capture happens in the waiting cycle, two cycles before the first byte
      model_local[f_sel[idx]] = time48_t'(burst_time - 48'd2);
    end else if (idx > 0) begin
      gap = burst_start - last_end - 1;
      if (gap < `TX_IFG_CYCLES) begin
        errors++;
        $display("ERROR: frame %0d started after only %0d idle cycles", idx, gap);
      end
    end
  endtask

  // GMII monitor sampling on the falling edge
  initial begin
    in_burst   = 1'b0;
    cyc        = 0;
    last_end   = 0;
    time_valid = 1'b0;
    exp_time   = '0;
    forever begin
      @(negedge gmii_tx_clk);
      cyc++;
      // time base counts up by one per cycle from zero after reset
      if (time_valid) begin
        compare_value("global_time", exp_time, global_time);
      end
      if (sys_rst === 1'b1) begin
        time_valid = 1'b1;
        exp_time   = '0;
      end else begin
        exp_time = time48_t'(exp_time + 48'd1);
      end
      if (gmii_tx_en === 1'b1) begin
        if (!in_burst) begin
          in_burst    = 1'b1;
          burst_start = cyc;
          burst_time  = global_time;
          burst.delete();
        end
        burst.push_back(gmii_txd);
      end else if (in_burst) begin
        in_burst = 1'b0;
        check_frame();
        last_end = cyc - 1;
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge gmii_tx_clk);
    $display("ERROR: watchdog expired with %0d of %0d frames received", rx_count, NUM_FRAMES);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    time48_t now;
    seed         = 32'h853a_703b;
    errors       = 0;
    sent_count   = 0;
    rx_count     = 0;
    sys_rst      = 1'b1;
    host_wr_en   = 1'b0;
    host_wr_data = '0;
    host_commit  = 1'b0;
    for (int k = 1; k <= `TX_NUM_TIMERS; k++) begin
      model_local[k] = '0;
    end
    repeat (5) @(posedge gmii_tx_clk);
    sys_rst <= 1'b0;
    @(negedge gmii_tx_clk);
    compare_value("reset buffer_full", 1'b0, buffer_full);
    compare_value("reset gmii_tx_en", 1'b0, gmii_tx_en);

    for (int f = 0; f < NUM_FRAMES; f++) begin
      f_kind[f] = {$random(seed)} % 4;
      f_len[f]  = 2 * (1 + {$random(seed)} % (MAX_LEN / 2));
      for (int i = 0; i < MAX_LEN; i++) begin
        f_pay[f][i] = 8'($random(seed));
      end
      // only immediate frames may queue behind others
      if (f_kind[f] != KIND_IMM) begin
        while (rx_count < f) begin
          @(negedge gmii_tx_clk);
        end
      end
      @(negedge gmii_tx_clk);
      now = global_time;
      f_target[f] = time48_t'(now + 48'd60 + 48'({$random(seed)} % 64));
      case (f_kind[f])
        KIND_IMM: begin
          f_sel[f] = 3'($random(seed));
          f_ofs[f] = '0;
        end
        KIND_ZERO: begin
          f_sel[f] = 3'd0;
          f_ofs[f] = f_target[f];
        end
        KIND_LOCAL: begin
          f_sel[f] = 3'd1 + 3'({$random(seed)} % 7);
          f_ofs[f] = time48_t'(f_target[f] - model_local[f_sel[f]]);
        end
        default: begin
          f_sel[f] = 3'd1 + 3'({$random(seed)} % 7);
          f_ofs[f] = 48'($random(seed));
        end
      endcase
      write_frame(f);
    end

    while (rx_count < NUM_FRAMES) begin
      @(negedge gmii_tx_clk);
    end
    // nothing further may come out
    repeat (200) @(negedge gmii_tx_clk);
    compare_value("frames received", NUM_FRAMES, rx_count);

    $display("errors: %0d, frames sent: %0d, frames received: %0d",
             errors, sent_count, rx_count);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
